/* src/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// word and address sizes
`define CPU_DATA_W   16
`define CPU_ADDR_W   10

// memory sizes in words
`define CPU_IM_DEPTH 1024
`define CPU_DM_DEPTH 1024

`endif

/* src/cpu_pkg.sv */
`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

    typedef logic [`CPU_DATA_W-1:0] data_t;
    typedef logic [`CPU_ADDR_W-1:0] addr_t;

    // opcode sits in the top 6 bits of an instruction word
    typedef enum logic [5:0] {
        OP_NOP    = 6'd0,  OP_LDAC   = 6'd1,  OP_LDIAC  = 6'd2,  OP_STAC   = 6'd3,
        OP_MVACAR = 6'd4,  OP_MVACR  = 6'd5,  OP_MVACR1 = 6'd6,  OP_MVACR2 = 6'd7,
        OP_MVACR3 = 6'd8,  OP_MVACR4 = 6'd9,  OP_MVR1AC = 6'd10, OP_MVR2AC = 6'd11,
        OP_MVR3AC = 6'd12, OP_MVR4AC = 6'd13, OP_ADD    = 6'd14, OP_SUB    = 6'd15,
        OP_MULT   = 6'd16, OP_LSHIFT = 6'd17, OP_INAC   = 6'd18, OP_CLAC   = 6'd19,
        OP_JPNZ   = 6'd20, OP_JMPZ   = 6'd21, OP_ENDOP  = 6'd22
    } opcode_t;

    typedef struct packed {
        opcode_t opcode;
        addr_t   operand;
    } instr_t;

    typedef enum logic [5:0] {
        S_START = 6'd0, S_FETCH1, S_FETCH2,
        S_NOP, S_LDAC1, S_LDAC2, S_LDIAC1, S_LDIAC2, S_STAC,
        S_MVACAR, S_MVACR, S_MVACR1, S_MVACR2, S_MVACR3, S_MVACR4,
        S_MVR1AC, S_MVR2AC, S_MVR3AC, S_MVR4AC,
        S_ADD, S_SUB, S_MULT, S_LSHIFT, S_INAC, S_CLAC,
        S_JPNZ1, S_JPNZ2, S_JMPZ1, S_JMPZ2, S_ENDOP
    } state_t;

    typedef enum logic [2:0] {
        ALU_PASS = 3'd0, ALU_ADD = 3'd1, ALU_SUB = 3'd2, ALU_MULT = 3'd3, ALU_LSHIFT = 3'd4
    } alu_op_t;

    typedef enum logic [3:0] {
        BUS_NONE, BUS_PC, BUS_IR, BUS_AC, BUS_R,
        BUS_R1, BUS_R2, BUS_R3, BUS_R4, BUS_DM, BUS_IM
    } bus_src_t;

    // bit positions in the enable vectors
    typedef enum logic [3:0] {
        REG_PC, REG_AR, REG_IR, REG_AC, REG_R,
        REG_R1, REG_R2, REG_R3, REG_R4, REG_ALU_TO_AC
    } reg_idx_t;

    typedef logic [REG_ALU_TO_AC:0] en_t;

endpackage

`default_nettype wire

/* src/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  wire cpu_pkg::alu_op_t  alu_op,
    input  wire cpu_pkg::data_t    ac,
    input  wire cpu_pkg::data_t    r,
    output cpu_pkg::data_t         alu_result
);

    // all results wrap to the data width
    always_comb begin
        case (alu_op)
            cpu_pkg::ALU_ADD: begin
                alu_result = ac + r;
            end
            cpu_pkg::ALU_SUB: begin
                alu_result = ac - r;
            end
            cpu_pkg::ALU_MULT: begin
                alu_result = ac * r; // low half of product
            end
            cpu_pkg::ALU_LSHIFT: begin
                alu_result = ac << 1;
            end
            default: begin
                alu_result = ac; // pass
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/mem_block.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module mem_block #(
    parameter type word_t = cpu_pkg::data_t,
    parameter int  DEPTH  = `CPU_DM_DEPTH
) (
    input  wire logic            clk,
    input  wire logic            we,
    input  wire cpu_pkg::addr_t  addr,
    input  wire word_t           wdata,
    input  wire logic            load_we,
    input  wire cpu_pkg::addr_t  load_addr,
    input  wire word_t           load_data,
    input  wire cpu_pkg::addr_t  dump_addr,
    output word_t                rdata,
    output word_t                dump_data
);

    word_t mem [DEPTH];

    // external load port wins over the core port
    always_ff @(posedge clk) begin
        if (load_we) begin
            mem[load_addr] <= load_data;
        end else if (we) begin
            mem[addr] <= wdata;
        end
    end

    assign rdata     = mem[addr]; // same-cycle read
    assign dump_data = mem[dump_addr];

endmodule

`default_nettype wire

/* src/reg_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_bank (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire cpu_pkg::en_t       write_en,
    input  wire cpu_pkg::en_t       inc_en,
    input  wire cpu_pkg::en_t       clr_en,
    input  wire cpu_pkg::bus_src_t  bus_src,
    input  wire cpu_pkg::data_t     alu_result,
    input  wire cpu_pkg::instr_t    im_data,
    input  wire cpu_pkg::data_t     dm_data,
    output cpu_pkg::data_t          bus,
    output cpu_pkg::addr_t          pc,
    output cpu_pkg::addr_t          ar,
    output cpu_pkg::data_t          ac,
    output cpu_pkg::data_t          r,
    output cpu_pkg::opcode_t        opcode,
    output logic                    zero
);

    cpu_pkg::instr_t ir;
    cpu_pkg::data_t  r1, r2, r3, r4;
    logic            ac_wr;
    cpu_pkg::data_t  ac_din;

    // clear, then load from bus, then increment
    function automatic cpu_pkg::data_t upd(cpu_pkg::data_t cur, cpu_pkg::reg_idx_t idx);
        if (clr_en[idx]) return '0;
        if (write_en[idx]) return bus;
        if (inc_en[idx]) return cur + 1'b1;
        return cur;
    endfunction

    always_comb begin
        case (bus_src)
            cpu_pkg::BUS_PC: bus = cpu_pkg::data_t'(pc);
            cpu_pkg::BUS_IR: bus = cpu_pkg::data_t'(ir.operand); // zero extended
            cpu_pkg::BUS_AC: bus = ac;
            cpu_pkg::BUS_R:  bus = r;
            cpu_pkg::BUS_R1: bus = r1;
            cpu_pkg::BUS_R2: bus = r2;
            cpu_pkg::BUS_R3: bus = r3;
            cpu_pkg::BUS_R4: bus = r4;
            cpu_pkg::BUS_DM: bus = dm_data;
            cpu_pkg::BUS_IM: bus = im_data;
            default:         bus = '0;
        endcase
    end

    assign ac_wr  = write_en[cpu_pkg::REG_AC] | write_en[cpu_pkg::REG_ALU_TO_AC];
    assign ac_din = write_en[cpu_pkg::REG_ALU_TO_AC] ? alu_result : bus;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
            ir <= '0;
        end else begin
            pc <= cpu_pkg::addr_t'(upd(cpu_pkg::data_t'(pc), cpu_pkg::REG_PC)); // wraps at 10 bits
            if (write_en[cpu_pkg::REG_IR]) begin
                ir <= cpu_pkg::instr_t'(bus);
            end
        end
    end

    always_ff @(posedge clk) begin
        ar <= cpu_pkg::addr_t'(upd(cpu_pkg::data_t'(ar), cpu_pkg::REG_AR));
        r  <= upd(r, cpu_pkg::REG_R);
        r1 <= upd(r1, cpu_pkg::REG_R1);
        r2 <= upd(r2, cpu_pkg::REG_R2);
        r3 <= upd(r3, cpu_pkg::REG_R3);
        r4 <= upd(r4, cpu_pkg::REG_R4);
        if (clr_en[cpu_pkg::REG_AC]) begin
            ac <= '0;
        end else if (ac_wr) begin
            ac <= ac_din;
        end else if (inc_en[cpu_pkg::REG_AC]) begin
            ac <= ac + 1'b1;
        end
    end

    assign opcode = ir.opcode;
    assign zero   = (ac == '0);

endmodule

`default_nettype wire

/* src/control.sv */
`timescale 1ns/1ns
`default_nettype none

module control (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire cpu_pkg::opcode_t  opcode,
    input  wire logic              zero,
    output cpu_pkg::en_t           write_en,
    output cpu_pkg::en_t           inc_en,
    output cpu_pkg::en_t           clr_en,
    output cpu_pkg::bus_src_t      bus_src,
    output cpu_pkg::alu_op_t       alu_op,
    output logic                   dm_we,
    output logic                   halted
);

    cpu_pkg::state_t state;
    cpu_pkg::state_t next_state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= cpu_pkg::S_START;
            halted <= 1'b0;
        end else begin
            state <= next_state;
            if (state == cpu_pkg::S_ENDOP) begin
                halted <= 1'b1; // sticky until rst
            end
        end
    end

    always_comb begin
        write_en   = '0;
        inc_en     = '0;
        clr_en     = '0;
        bus_src    = cpu_pkg::BUS_NONE;
        alu_op     = cpu_pkg::ALU_PASS;
        dm_we      = 1'b0;
        next_state = cpu_pkg::S_FETCH1; // most states return to fetch
        case (state)
            cpu_pkg::S_START: begin
                clr_en[cpu_pkg::REG_PC] = 1'b1;
                clr_en[cpu_pkg::REG_AR] = 1'b1;
            end
            cpu_pkg::S_FETCH1: begin
                bus_src                   = cpu_pkg::BUS_IM;
                write_en[cpu_pkg::REG_IR] = 1'b1;
                next_state                = cpu_pkg::S_FETCH2;
            end
            cpu_pkg::S_FETCH2: begin
                inc_en[cpu_pkg::REG_PC] = 1'b1;
                case (opcode)
                    cpu_pkg::OP_NOP:    next_state = cpu_pkg::S_NOP;
                    cpu_pkg::OP_LDAC:   next_state = cpu_pkg::S_LDAC1;
                    cpu_pkg::OP_LDIAC:  next_state = cpu_pkg::S_LDIAC1;
                    cpu_pkg::OP_STAC:   next_state = cpu_pkg::S_STAC;
                    cpu_pkg::OP_MVACAR: next_state = cpu_pkg::S_MVACAR;
                    cpu_pkg::OP_MVACR:  next_state = cpu_pkg::S_MVACR;
                    cpu_pkg::OP_MVACR1: next_state = cpu_pkg::S_MVACR1;
                    cpu_pkg::OP_MVACR2: next_state = cpu_pkg::S_MVACR2;
                    cpu_pkg::OP_MVACR3: next_state = cpu_pkg::S_MVACR3;
                    cpu_pkg::OP_MVACR4: next_state = cpu_pkg::S_MVACR4;
                    cpu_pkg::OP_MVR1AC: next_state = cpu_pkg::S_MVR1AC;
                    cpu_pkg::OP_MVR2AC: next_state = cpu_pkg::S_MVR2AC;
                    cpu_pkg::OP_MVR3AC: next_state = cpu_pkg::S_MVR3AC;
                    cpu_pkg::OP_MVR4AC: next_state = cpu_pkg::S_MVR4AC;
                    cpu_pkg::OP_ADD:    next_state = cpu_pkg::S_ADD;
                    cpu_pkg::OP_SUB:    next_state = cpu_pkg::S_SUB;
                    cpu_pkg::OP_MULT:   next_state = cpu_pkg::S_MULT;
                    cpu_pkg::OP_LSHIFT: next_state = cpu_pkg::S_LSHIFT;
                    cpu_pkg::OP_INAC:   next_state = cpu_pkg::S_INAC;
                    cpu_pkg::OP_CLAC:   next_state = cpu_pkg::S_CLAC;
                    cpu_pkg::OP_JPNZ:   next_state = cpu_pkg::S_JPNZ1;
                    cpu_pkg::OP_JMPZ:   next_state = cpu_pkg::S_JMPZ1;
                    default:            next_state = cpu_pkg::S_ENDOP; // endop or bad code
                endcase
            end
            cpu_pkg::S_NOP: ;
            cpu_pkg::S_LDAC1: begin
                bus_src                   = cpu_pkg::BUS_AC; // address held in ac
                write_en[cpu_pkg::REG_AR] = 1'b1;
                next_state                = cpu_pkg::S_LDAC2;
            end
            cpu_pkg::S_LDIAC1: begin
                bus_src                   = cpu_pkg::BUS_IR; // address from operand
                write_en[cpu_pkg::REG_AR] = 1'b1;
                next_state                = cpu_pkg::S_LDIAC2;
            end
            cpu_pkg::S_LDAC2, cpu_pkg::S_LDIAC2: begin
                bus_src                   = cpu_pkg::BUS_DM;
                write_en[cpu_pkg::REG_AC] = 1'b1;
            end
            cpu_pkg::S_STAC: begin
                bus_src = cpu_pkg::BUS_AC;
                dm_we   = 1'b1;
            end
            cpu_pkg::S_MVACAR: begin
                bus_src                   = cpu_pkg::BUS_AC;
                write_en[cpu_pkg::REG_AR] = 1'b1;
            end
            cpu_pkg::S_MVACR: begin
                bus_src                  = cpu_pkg::BUS_AC;
                write_en[cpu_pkg::REG_R] = 1'b1;
            end
            cpu_pkg::S_MVACR1: begin
                bus_src                   = cpu_pkg::BUS_AC;
                write_en[cpu_pkg::REG_R1] = 1'b1;
            end
            cpu_pkg::S_MVACR2: begin
                bus_src                   = cpu_pkg::BUS_AC;
                write_en[cpu_pkg::REG_R2] = 1'b1;
            end
            cpu_pkg::S_MVACR3: begin
                bus_src                   = cpu_pkg::BUS_AC;
                write_en[cpu_pkg::REG_R3] = 1'b1;
            end
            cpu_pkg::S_MVACR4: begin
                bus_src                   = cpu_pkg::BUS_AC;
                write_en[cpu_pkg::REG_R4] = 1'b1;
            end
            cpu_pkg::S_MVR1AC: begin
                bus_src                   = cpu_pkg::BUS_R1;
                write_en[cpu_pkg::REG_AC] = 1'b1;
            end
            cpu_pkg::S_MVR2AC: begin
                bus_src                   = cpu_pkg::BUS_R2;
                write_en[cpu_pkg::REG_AC] = 1'b1;
            end
            cpu_pkg::S_MVR3AC: begin
                bus_src                   = cpu_pkg::BUS_R3;
                write_en[cpu_pkg::REG_AC] = 1'b1;
            end
            cpu_pkg::S_MVR4AC: begin
                bus_src                   = cpu_pkg::BUS_R4;
                write_en[cpu_pkg::REG_AC] = 1'b1;
            end
            cpu_pkg::S_ADD: begin
                alu_op                           = cpu_pkg::ALU_ADD;
                write_en[cpu_pkg::REG_ALU_TO_AC] = 1'b1;
            end
            cpu_pkg::S_SUB: begin
                alu_op                           = cpu_pkg::ALU_SUB;
                write_en[cpu_pkg::REG_ALU_TO_AC] = 1'b1;
            end
            cpu_pkg::S_MULT: begin
                alu_op                           = cpu_pkg::ALU_MULT;
                write_en[cpu_pkg::REG_ALU_TO_AC] = 1'b1;
            end
            cpu_pkg::S_LSHIFT: begin
                alu_op                           = cpu_pkg::ALU_LSHIFT;
                write_en[cpu_pkg::REG_ALU_TO_AC] = 1'b1;
            end
            cpu_pkg::S_INAC: inc_en[cpu_pkg::REG_AC] = 1'b1;
            cpu_pkg::S_CLAC: clr_en[cpu_pkg::REG_AC] = 1'b1;
            cpu_pkg::S_JPNZ1: next_state = zero ? cpu_pkg::S_FETCH1 : cpu_pkg::S_JPNZ2;
            cpu_pkg::S_JMPZ1: next_state = zero ? cpu_pkg::S_JMPZ2 : cpu_pkg::S_FETCH1;
            cpu_pkg::S_JPNZ2, cpu_pkg::S_JMPZ2: begin
                bus_src                   = cpu_pkg::BUS_IR; // branch target
                write_en[cpu_pkg::REG_PC] = 1'b1;
            end
            default: next_state = cpu_pkg::S_ENDOP; // ENDOP parks here
        endcase
    end

endmodule

`default_nettype wire

/* src/cpu_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module cpu_top (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              im_load_we,
    input  wire cpu_pkg::addr_t    im_load_addr,
    input  wire cpu_pkg::instr_t   im_load_data,
    input  wire logic              dm_load_we,
    input  wire cpu_pkg::addr_t    dm_load_addr,
    input  wire cpu_pkg::data_t    dm_load_data,
    input  wire cpu_pkg::addr_t    dump_addr,
    output wire cpu_pkg::data_t    dump_data,
    output wire cpu_pkg::data_t    ac,
    output wire cpu_pkg::addr_t    pc,
    output wire logic              halted
);

    wire cpu_pkg::en_t       write_en;
    wire cpu_pkg::en_t       inc_en;
    wire cpu_pkg::en_t       clr_en;
    wire cpu_pkg::bus_src_t  bus_src;
    wire cpu_pkg::alu_op_t   alu_op;
    wire logic               dm_we;
    wire cpu_pkg::data_t     bus;
    wire cpu_pkg::addr_t     ar;
    wire cpu_pkg::data_t     r;
    wire cpu_pkg::opcode_t   opcode;
    wire logic               zero;
    wire cpu_pkg::data_t     alu_result;
    wire cpu_pkg::instr_t    im_data;
    wire cpu_pkg::data_t     dm_data;

    control u_control (
        .clk, .rst, .opcode, .zero,
        .write_en, .inc_en, .clr_en, .bus_src, .alu_op, .dm_we, .halted
    );

    reg_bank u_reg_bank (
        .clk, .rst, .write_en, .inc_en, .clr_en, .bus_src,
        .alu_result, .im_data, .dm_data,
        .bus, .pc, .ar, .ac, .r, .opcode, .zero
    );

    alu u_alu (.alu_op, .ac, .r, .alu_result);

    // program store, written only through the load port
    mem_block #(.word_t(cpu_pkg::instr_t), .DEPTH(`CPU_IM_DEPTH)) im (
        .clk, .we(1'b0), .addr(pc), .wdata('0),
        .load_we(im_load_we), .load_addr(im_load_addr), .load_data(im_load_data),
        .dump_addr('0), .rdata(im_data), .dump_data()
    );

    mem_block #(.word_t(cpu_pkg::data_t), .DEPTH(`CPU_DM_DEPTH)) dm (
        .clk, .we(dm_we), .addr(ar), .wdata(bus),
        .load_we(dm_load_we), .load_addr(dm_load_addr), .load_data(dm_load_data),
        .dump_addr, .rdata(dm_data), .dump_data
    );

endmodule

`default_nettype wire

/* verif/cpu_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_tb;

    logic             clk = 1'b0;
    logic             rst;
    logic             im_load_we;
    cpu_pkg::addr_t   im_load_addr;
    cpu_pkg::instr_t  im_load_data;
    logic             dm_load_we;
    cpu_pkg::addr_t   dm_load_addr;
    cpu_pkg::data_t   dm_load_data;
    cpu_pkg::addr_t   dump_addr;
    cpu_pkg::data_t   dump_data;
    cpu_pkg::data_t   ac;
    cpu_pkg::addr_t   pc;
    logic             halted;

    // current case from the cases file or the generator
    string            case_name;
    cpu_pkg::addr_t   prog_addr [$];
    cpu_pkg::instr_t  prog_word [$];
    cpu_pkg::addr_t   dm_addr [$];
    cpu_pkg::data_t   dm_word [$];
    cpu_pkg::addr_t   mem_addr [$];
    cpu_pkg::data_t   mem_word [$];
    cpu_pkg::data_t   exp_ac;
    cpu_pkg::addr_t   exp_pc;
    logic             has_ac;
    logic             has_pc;
    logic [15:0]      rng = 16'd12;
    int               fd;
    int               cases_run = 0;

    cpu_top UUT (
        .clk, .rst, .im_load_we, .im_load_addr, .im_load_data,
        .dm_load_we, .dm_load_addr, .dm_load_data, .dump_addr,
        .dump_data, .ac, .pc, .halted
    );

    always #20 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input cpu_pkg::data_t exp,
                              input cpu_pkg::data_t act);
        if (act !== exp) begin
            report_failure($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input cpu_pkg::addr_t exp,
                              input cpu_pkg::addr_t act);
        if (act !== exp) begin
            report_failure($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
        end
    endtask

    // 16-bit xorshift with shifts 7 9 8
    function automatic logic [15:0] xorshift16(input logic [15:0] x);
        logic [15:0] y;
        y = x ^ (x << 7);
        y = y ^ (y >> 9);
        return y ^ (y << 8);
    endfunction

    task automatic clear_case();
        prog_addr.delete();
        prog_word.delete();
        dm_addr.delete();
        dm_word.delete();
        mem_addr.delete();
        mem_word.delete();
        has_ac = 1'b0;
        has_pc = 1'b0;
    endtask

    task automatic add_instr(input cpu_pkg::opcode_t op, input cpu_pkg::addr_t operand);
        cpu_pkg::instr_t w;
        w.opcode  = op;
        w.operand = operand;
        prog_addr.push_back(cpu_pkg::addr_t'(prog_word.size()));
        prog_word.push_back(w);
    endtask

    // start address then words up to a lone dot
    task automatic read_list(input int kind);
        logic [255:0]   tok;
        logic [15:0]    word;
        cpu_pkg::addr_t a;
        int             code;
        code = $fscanf(fd, "%h", word);
        if (code != 1) report_failure("cases file has a list without a start address");
        a = cpu_pkg::addr_t'(word);
        for (int n = 0; n < 1024; n++) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) report_failure("cases file ends inside a list");
            if (tok == ".") break;
            code = $sscanf(tok, "%h", word);
            if (code != 1) report_failure("cases file has a list word that is not hex");
            case (kind)
                0: begin
                    prog_addr.push_back(a);
                    prog_word.push_back(cpu_pkg::instr_t'(word));
                end
                1: begin
                    dm_addr.push_back(a);
                    dm_word.push_back(word);
                end
                default: begin
                    mem_addr.push_back(a);
                    mem_word.push_back(word);
                end
            endcase
            a = a + 10'd1;
        end
    endtask

    // operands at dm 000 and 001 and results stored to dm 100 to 104
    task automatic build_alu_case(input string name, input int round);
        cpu_pkg::data_t   a;
        cpu_pkg::data_t   b;
        cpu_pkg::data_t   res;
        cpu_pkg::opcode_t op;
        cpu_pkg::opcode_t park_op;
        cpu_pkg::opcode_t restore_op;
        clear_case();
        rng = xorshift16(rng);
        a   = rng;
        rng = xorshift16(rng);
        b   = rng;
        case_name = $sformatf("%0s_%0d", name, round);
        dm_addr.push_back(10'h000);
        dm_word.push_back(a);
        dm_addr.push_back(10'h001);
        dm_word.push_back(b);
        add_instr(cpu_pkg::OP_LDIAC, 10'h001);
        add_instr(cpu_pkg::OP_MVACR, 10'h000); // r holds b for the whole program
        for (int k = 0; k < 5; k++) begin
            case (k)
                0: begin
                    op  = cpu_pkg::OP_ADD;
                    res = a + b;
                end
                1: begin
                    op  = cpu_pkg::OP_SUB;
                    res = a - b;
                end
                2: begin
                    op  = cpu_pkg::OP_MULT;
                    res = a * b;
                end
                3: begin
                    op  = cpu_pkg::OP_LSHIFT;
                    res = a << 1;
                end
                default: begin
                    op  = cpu_pkg::OP_INAC;
                    res = a + 16'd1;
                end
            endcase
            // result waits in r1 to r4 in turn
            park_op    = cpu_pkg::opcode_t'(cpu_pkg::OP_MVACR1 + k % 4);
            restore_op = cpu_pkg::opcode_t'(cpu_pkg::OP_MVR1AC + k % 4);
            dm_addr.push_back(cpu_pkg::addr_t'(16 + k));
            dm_word.push_back(cpu_pkg::data_t'(256 + k));
            add_instr(cpu_pkg::OP_LDIAC, 10'h000);
            add_instr(op, 10'h000);
            add_instr(park_op, 10'h000);
            add_instr(cpu_pkg::OP_LDIAC, cpu_pkg::addr_t'(16 + k));
            add_instr(cpu_pkg::OP_MVACAR, 10'h000);
            add_instr(restore_op, 10'h000);
            add_instr(cpu_pkg::OP_STAC, 10'h000);
            mem_addr.push_back(cpu_pkg::addr_t'(256 + k));
            mem_word.push_back(res);
        end
        add_instr(cpu_pkg::OP_ENDOP, 10'h000);
        exp_ac = res;
        exp_pc = cpu_pkg::addr_t'(prog_word.size()); // one past endop
        has_ac = 1'b1;
        has_pc = 1'b1;
    endtask

    task automatic load_word(input logic to_im, input cpu_pkg::addr_t a, input logic [15:0] w);
        @(negedge clk);
        if (halted !== 1'b0) report_failure({case_name, ": halted is high during reset"});
        im_load_we   = to_im;
        im_load_addr = a;
        im_load_data = cpu_pkg::instr_t'(w);
        dm_load_we   = ~to_im;
        dm_load_addr = a;
        dm_load_data = w;
    endtask

    task automatic run_case();
        int cycles;
        @(negedge clk);
        rst = 1'b1;
        foreach (mem_addr[i]) begin
            load_word(1'b0, mem_addr[i], cpu_pkg::data_t'(mem_addr[i]) ^ 16'ha5a5);
        end
        foreach (dm_addr[i]) load_word(1'b0, dm_addr[i], dm_word[i]);
        foreach (prog_addr[i]) load_word(1'b1, prog_addr[i], prog_word[i]);
        for (int i = 0; i < 4; i++) begin
            load_word(1'b0, 10'h000, 16'h0000);
            dm_load_we = 1'b0;
        end
        @(negedge clk);
        rst    = 1'b0;
        cycles = 0;
        while (halted !== 1'b1 && cycles < 2000) begin
            @(negedge clk);
            cycles++;
        end
        if (halted !== 1'b1) report_failure({case_name, ": no halt within 2000 cycles"});
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            if (halted !== 1'b1) report_failure({case_name, ": halted dropped before reset"});
        end
        if (has_ac) check_data({case_name, " ac"}, exp_ac, ac);
        if (has_pc) check_addr({case_name, " pc"}, exp_pc, pc);
        foreach (mem_addr[i]) begin
            @(negedge clk);
            dump_addr = mem_addr[i];
            @(posedge clk);
            check_data($sformatf("%0s dm[%h]", case_name, mem_addr[i]), mem_word[i], dump_data);
        end
        cases_run++;
        clear_case();
    endtask

    initial begin
        logic [255:0] tok;
        logic [8*256-1:0] line;
        logic [15:0]  word;
        int           rounds;
        int           code;
        rst          = 1'b1;
        im_load_we   = 1'b0;
        im_load_addr = '0;
        im_load_data = '0;
        dm_load_we   = 1'b0;
        dm_load_addr = '0;
        dm_load_data = '0;
        dump_addr    = '0;
        case_name    = "none";
        clear_case();
        fd = $fopen("verif/cpu_cases.txt", "r");
        if (fd == 0) report_failure("cannot open verif/cpu_cases.txt");
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                void'($fgets(line, fd)); // comment line
            end else if (tok == "case") begin
                code = $fscanf(fd, "%s", tok);
                if (code != 1) report_failure("cases file has a case record without a name");
                case_name = $sformatf("%0s", tok);
            end else if (tok == "prog") begin
                read_list(0);
            end else if (tok == "data") begin
                read_list(1);
            end else if (tok == "mem") begin
                read_list(2);
            end else if (tok == "ac") begin
                code = $fscanf(fd, "%h", word);
                if (code != 1) report_failure("cases file has an ac record without a value");
                exp_ac = word;
                has_ac = 1'b1;
            end else if (tok == "pc") begin
                code = $fscanf(fd, "%h", word);
                if (code != 1) report_failure("cases file has a pc record without a value");
                exp_pc = cpu_pkg::addr_t'(word);
                has_pc = 1'b1;
            end else if (tok == "gen") begin
                code = $fscanf(fd, "%s %d", tok, rounds);
                if (code != 2) report_failure("cases file has a gen record without name or count");
                for (int r = 0; r < rounds; r++) begin
                    build_alu_case($sformatf("%0s", tok), r);
                    run_case();
                end
            end else if (tok == "end") begin
                run_case();
            end else begin
                report_failure("unknown record in verif/cpu_cases.txt");
            end
        end
        $fclose(fd);
        if (cases_run == 0) begin
            report_failure("no test cases were found in verif/cpu_cases.txt");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verif/cpu_cases.txt */
# records: case <name> | prog <addr> <instr words> . | data <addr> <words> . | mem <addr> <words> .
#          ac <word> | pc <addr> | gen <name> <rounds> | end   (numbers hex, rounds decimal)
case load_store
data 010 1234 0020 0030 .
data 030 beef .
prog 000 0811 1800 0810 1c00 2800 1000 2c00 0c00 0812 0400 5800 .
ac beef
pc 00b
mem 020 1234 .
end
case reg_moves
data 000 00a5 .
prog 000 0800 1800 4800 1c00 4800 2000 4800 2400 4c00 3400 4c00 2800 3000 2c00 5800 .
ac 00a6
pc 00f
end
gen alu_random 3
case cond_jumps
data 001 0040 0041 0042 0043 .
prog 000 0801 1000 5004 5800 4800 0c00 0802 1000 4c00 5003 4800 4800 0c00 .
prog 00d 0803 1000 4c00 5412 5800 4800 0c00 0804 1000 5403 4400 0c00 5800 .
ac 0086
pc 01a
mem 040 0041 0002 0001 0086 .
end
case count_loop
data 000 0006 .
prog 000 4c00 4800 1400 1800 0800 1c00 2800 4400 1800 2c00 3c00 5005 2800 5800 .
ac 0040
pc 00e
end

/* project.f */
+incdir+src
src/cpu_pkg.sv
src/alu.sv
src/mem_block.sv
src/reg_bank.sv
src/control.sv
src/cpu_top.sv
verif/cpu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
LOG=sim.log
{ verilator --binary --timing -Wno-fatal --top-module cpu_tb -f project.f -Mdir obj_dir \
    && ./obj_dir/Vcpu_tb; } > "$LOG" 2>&1 || echo "CHECKS FAILED" >> "$LOG"
cat "$LOG"
grep -q "CHECKS FAILED" "$LOG" && exit 1 || exit 0
